// ==== hw/mac_glue_pkg.sv ====
// Mac Plus glue definitions
`default_nettype none

package mac_glue_pkg;

	// ------------------------------------------------------------
	// bus slots
	// ------------------------------------------------------------

	// four slots per 16-clock bus cycle, each four clk32 long
	typedef enum logic [1:0] {
		SLOT_VIDEO = 2'd0,
		SLOT_CPU_A = 2'd1,
		SLOT_IO    = 2'd2,
		SLOT_CPU_B = 2'd3
	} slot_t;

	// ------------------------------------------------------------
	// reset and floppy sizes
	// ------------------------------------------------------------

	// hold length in clk8 ticks, roughly 8 ms
	localparam logic [15:0] RESET_HOLD = 16'd65535;

	// final word address seen at the end of a download
	// 819200 bytes is double sided, 409600 bytes single sided
	localparam logic [22:0] FLOPPY_DS_WORDS = 23'd409600;
	localparam logic [22:0] FLOPPY_SS_WORDS = 23'd204800;

	// ------------------------------------------------------------
	// download indices and SDRAM regions
	// ------------------------------------------------------------

	localparam logic [4:0] IDX_ROM      = 5'd0;
	localparam logic [4:0] IDX_DISK_INT = 5'd1;
	localparam logic [4:0] IDX_DISK_EXT = 5'd2;

	// disk images sit after the os rom, as word offsets
	localparam logic [20:0] DISK_INT_BASE = 21'h80000;
	localparam logic [20:0] DISK_EXT_BASE = 21'h100000;

	// upper nibble of every download address
	localparam logic [3:0] DL_REGION_TAG = 4'b0001;

	// autovector space and interrupt acknowledge
	localparam logic [2:0] IO_SPACE_TOP = 3'b111;
	localparam logic [2:0] FC_INTACK    = 3'b111;

	// ------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------

	// host loader side
	typedef struct packed {
		logic        active;
		logic [4:0]  index;
		logic        wr;
		logic [23:0] addr;
		logic [7:0]  data;
	} download_t;

	// chipset memory request, strobes active low
	typedef struct packed {
		logic [21:0] addr;
		logic        rom_oe_n;
		logic        ram_oe_n;
		logic        ram_we_n;
		logic        uds_n;
		logic        lds_n;
		logic [15:0] wdata;
	} chip_mem_t;

	// request toward the SDRAM controller
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] din;
		logic [1:0]  ds;
		logic        we;
		logic        oe;
	} sdram_req_t;

	// 68000 strobe side, word address only
	typedef struct packed {
		logic        as_n;
		logic [2:0]  fc;
		logic [23:1] addr;
	} cpu_bus_t;

	// bit 0 is the internal drive
	typedef struct packed {
		logic [1:0] inserted;
		logic [1:0] double_sided;
	} disk_status_t;

endpackage

`default_nettype wire

// ==== hw/bus_phase_gen.sv ====
// Bus phase generator
`timescale 1ns/10ps
`default_nettype none

module bus_phase_gen
	import mac_glue_pkg::*;
(
	input  logic clk32,
	input  logic reset,
	output logic clk8_en_p,
	output logic clk8_en_n,
	output logic clk16_en_p,
	output logic clk16_en_n,
	output logic video_bus,
	output logic cpu_bus,
	output logic dio_bus
);

	// low two bits pick the clk8 phase, upper two the slot
	logic [3:0] phase;
	slot_t      slot;

	always_ff @(posedge clk32) begin
		if (reset) begin
			phase <= 4'd0;
		end else begin
			phase <= phase + 4'd1;
		end
	end

	// clock enables
	assign clk8_en_p  = (phase[1:0] == 2'd0);
	assign clk8_en_n  = (phase[1:0] == 2'd2);
	assign clk16_en_p = ~phase[0];
	assign clk16_en_n = phase[0];

	// slot ownership: video, cpu, io, cpu
	assign slot      = slot_t'(phase[3:2]);
	assign video_bus = (slot == SLOT_VIDEO);
	assign cpu_bus   = (slot == SLOT_CPU_A) || (slot == SLOT_CPU_B);
	assign dio_bus   = (slot == SLOT_IO);

endmodule

`default_nettype wire

// ==== hw/reset_sequencer.sv ====
// System reset sequencer
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer
	import mac_glue_pkg::*;
(
	input  logic      clk32,
	input  logic      reset,
	input  logic      clk8_en_p,
	input  logic      user_reset,
	input  logic      mem_config,
	input  download_t download,
	output logic      n_reset
);

	logic [15:0] hold_cnt;
	logic        last_mem_config;
	logic        rom_download;
	logic        cause;

	// the rom is being replaced, keep the machine down
	assign rom_download = download.active && (download.index == IDX_ROM);

	// memory size change restarts the machine
	assign cause = user_reset || rom_download || (last_mem_config != mem_config);

	// ------------------------------------------------------------
	// hold counter, counts clk8 ticks
	// ------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset) begin
			hold_cnt        <= RESET_HOLD;
			last_mem_config <= mem_config;
		end else if (clk8_en_p) begin
			last_mem_config <= mem_config;
			// any cause reloads the full hold
			if (cause) begin
				hold_cnt <= RESET_HOLD;
			end else if (hold_cnt != 16'd0) begin
				hold_cnt <= hold_cnt - 16'd1;
			end
		end
	end

	// released only once the count has run out
	assign n_reset = (hold_cnt == 16'd0);

endmodule

`default_nettype wire

// ==== hw/floppy_image_detect.sv ====
// Floppy image detector
`timescale 1ns/10ps
`default_nettype none

module floppy_image_detect
	import mac_glue_pkg::*;
(
	input  logic         clk32,
	input  logic         reset,
	input  download_t    download,
	input  logic [1:0]   disk_eject,
	output disk_status_t disk_status
);

	logic        active_d;
	logic        dl_end;
	logic [22:0] word_addr;
	logic [1:0]  drive_sel;
	logic [1:0]  ds_flag;
	logic [1:0]  ss_flag;

	// falling edge of download active marks the end of a transfer
	assign dl_end = active_d && !download.active;

	// addr counts bytes, the size check is in words
	assign word_addr = download.addr[23:1];

	// which drive the index names
	assign drive_sel[0] = (download.index == IDX_DISK_INT);
	assign drive_sel[1] = (download.index == IDX_DISK_EXT);

	always_ff @(posedge clk32) begin
		if (reset) begin
			active_d <= 1'b0;
		end else begin
			active_d <= download.active;
		end
	end

	// ------------------------------------------------------------
	// per drive size flags
	// ------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset) begin
			ds_flag <= 2'b00;
			ss_flag <= 2'b00;
		end else begin
			for (int d = 0; d < 2; d++) begin
				// eject wins over a finishing download
				if (disk_eject[d]) begin
					ds_flag[d] <= 1'b0;
					ss_flag[d] <= 1'b0;
				end else if (dl_end && drive_sel[d]) begin
					// unknown sizes leave both flags low
					ds_flag[d] <= (word_addr == FLOPPY_DS_WORDS);
					ss_flag[d] <= (word_addr == FLOPPY_SS_WORDS);
				end
			end
		end
	end

	// any known image counts as inserted
	assign disk_status.inserted     = ds_flag | ss_flag;
	assign disk_status.double_sided = ds_flag;

endmodule

`default_nettype wire

// ==== hw/download_port.sv ====
// Loader download port
`timescale 1ns/10ps
`default_nettype none

module download_port
	import mac_glue_pkg::*;
(
	input  logic        clk32,
	input  logic        reset,
	input  logic        dio_bus,
	input  download_t   download,
	output logic        ioctl_wait,
	output logic        dio_write,
	output logic [20:0] dl_word_addr
);

	logic        dio_bus_d;
	logic        write_pending;
	logic        slot_start;
	logic        slot_end;
	logic [20:0] byte_word;

	assign slot_start = dio_bus && !dio_bus_d;
	assign slot_end   = dio_bus_d && !dio_bus;

	// ------------------------------------------------------------
	// stall state
	// ------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset) begin
			dio_bus_d     <= 1'b0;
			write_pending <= 1'b0;
			ioctl_wait    <= 1'b0;
		end else begin
			dio_bus_d <= dio_bus;

			// stall the loader from the clock after its strobe
			if (download.wr) begin
				ioctl_wait <= 1'b1;
			end

			// outside the io slot a fresh strobe or the stall becomes a pending write
			if (!dio_bus) begin
				write_pending <= ioctl_wait || download.wr;
			end

			// io slot just ended with the write done
			if (slot_end && write_pending) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// single write strobe on the first clock of the io slot
	assign dio_write = write_pending && slot_start;

	// ------------------------------------------------------------
	// region mapping
	// ------------------------------------------------------------
	assign byte_word = download.addr[21:1];

	always_comb begin
		if (download.index == IDX_ROM) begin
			dl_word_addr = byte_word;
		end else if (download.index == IDX_DISK_INT) begin
			dl_word_addr = DISK_INT_BASE + byte_word;
		end else begin
			// every other index lands in the second disk region
			dl_word_addr = DISK_EXT_BASE + byte_word;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memory_port_mux.sv ====
// SDRAM port multiplexer
`timescale 1ns/10ps
`default_nettype none

module memory_port_mux
	import mac_glue_pkg::*;
(
	input  download_t   download,
	input  logic        dio_bus,
	input  logic        dio_write,
	input  logic        disk_read_ack,
	input  logic [20:0] dl_word_addr,
	input  chip_mem_t   chip_mem,
	input  logic [15:0] sdram_rdata,
	output sdram_req_t  sdram_req,
	output logic [15:0] cpu_rdata
);

	logic        dl_cycle;
	logic [15:0] disk_byte;

	// loader owns the io slot while a download runs
	assign dl_cycle = download.active && dio_bus;

	// ------------------------------------------------------------
	// request select
	// ------------------------------------------------------------
	always_comb begin
		if (dl_cycle) begin
			sdram_req.addr = {DL_REGION_TAG, dl_word_addr};
			sdram_req.din  = {download.data, download.data};
			// even byte goes to the upper lane
			sdram_req.ds   = {~download.addr[0], download.addr[0]};
			sdram_req.we   = dio_write;
			sdram_req.oe   = 1'b0;
		end else begin
			// rom select bit sits just above the 21 word address bits
			sdram_req.addr = {3'b000, ~chip_mem.rom_oe_n, chip_mem.addr[21:1]};
			sdram_req.din  = chip_mem.wdata;
			sdram_req.ds   = {~chip_mem.uds_n, ~chip_mem.lds_n};
			sdram_req.we   = ~chip_mem.ram_we_n;
			sdram_req.oe   = ~chip_mem.ram_oe_n || ~chip_mem.rom_oe_n;
		end
	end

	// ------------------------------------------------------------
	// read data shaping
	// ------------------------------------------------------------

	// disk images are byte wide, pick the half and repeat it
	assign disk_byte = chip_mem.addr[0] ? {sdram_rdata[7:0], sdram_rdata[7:0]}
		: {sdram_rdata[15:8], sdram_rdata[15:8]};

	// all ones during a download keeps the screen black
	assign cpu_rdata = dl_cycle ? 16'hffff
		: disk_read_ack ? disk_byte
		: sdram_rdata;

endmodule

`default_nettype wire

// ==== hw/cpu_bus_ack.sv ====
// 68000 bus acknowledge
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_ack
	import mac_glue_pkg::*;
(
	input  logic     clk32,
	input  logic     reset,
	input  logic     cpu_bus,
	input  logic     turbo,
	input  logic     not_memory,
	input  cpu_bus_t cpu,
	output logic     dtack_n,
	output logic     vpa_n
);

	logic cpu_bus_d;
	logic turbo_dtack_en;
	logic strobe;
	logic vpa_req;
	logic dtack_ok;

	assign strobe = !cpu.as_n;

	// ------------------------------------------------------------
	// turbo dtack enable
	// ------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset) begin
			cpu_bus_d      <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			cpu_bus_d <= cpu_bus;
			if (!strobe) begin
				turbo_dtack_en <= 1'b0;
			end else if ((cpu_bus && !cpu_bus_d) || not_memory) begin
				// memory waits for its cpu slot, peripherals answer at once
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// autovector space or interrupt acknowledge
	assign vpa_req = (cpu.fc == FC_INTACK)
		|| (strobe && (cpu.addr[23:21] == IO_SPACE_TOP));

	assign vpa_n = !vpa_req;

	// turbo holds dtack until the enable is set
	assign dtack_ok = !turbo || turbo_dtack_en;
	assign dtack_n  = !(strobe && !vpa_req && dtack_ok);

endmodule

`default_nettype wire

// ==== hw/mac_glue_top.sv ====
// Mac Plus glue top
`timescale 1ns/10ps
`default_nettype none

module mac_glue_top
	import mac_glue_pkg::*;
(
	input  logic         clk32,
	input  logic         reset,

	// loader
	input  download_t    download,
	output logic         ioctl_wait,

	// chipset
	input  chip_mem_t    chip_mem,
	input  cpu_bus_t     cpu,
	input  logic         turbo,
	input  logic         mem_config,
	input  logic         user_reset,
	input  logic         not_memory,
	input  logic         disk_read_ack,
	input  logic [1:0]   disk_eject,

	// sdram
	input  logic [15:0]  sdram_rdata,
	output sdram_req_t   sdram_req,

	// cpu and system
	output logic [15:0]  cpu_rdata,
	output logic         dtack_n,
	output logic         vpa_n,
	output logic         n_reset,
	output disk_status_t disk_status,

	// bus phase
	output logic         clk8_en_p,
	output logic         clk8_en_n,
	output logic         clk16_en_p,
	output logic         clk16_en_n,
	output logic         video_bus,
	output logic         cpu_bus,
	output logic         dio_bus
);

	logic        dio_write;
	logic [20:0] dl_word_addr;

	// ------------------------------------------------------------
	// timing and reset
	// ------------------------------------------------------------
	bus_phase_gen u_phase (
		.clk32      (clk32),
		.reset      (reset),
		.clk8_en_p  (clk8_en_p),
		.clk8_en_n  (clk8_en_n),
		.clk16_en_p (clk16_en_p),
		.clk16_en_n (clk16_en_n),
		.video_bus  (video_bus),
		.cpu_bus    (cpu_bus),
		.dio_bus    (dio_bus)
	);

	reset_sequencer u_reset (
		.clk32      (clk32),
		.reset      (reset),
		.clk8_en_p  (clk8_en_p),
		.user_reset (user_reset),
		.mem_config (mem_config),
		.download   (download),
		.n_reset    (n_reset)
	);

	// ------------------------------------------------------------
	// downloads and floppies
	// ------------------------------------------------------------
	floppy_image_detect u_floppy (
		.clk32       (clk32),
		.reset       (reset),
		.download    (download),
		.disk_eject  (disk_eject),
		.disk_status (disk_status)
	);

	download_port u_dl (
		.clk32        (clk32),
		.reset        (reset),
		.dio_bus      (dio_bus),
		.download     (download),
		.ioctl_wait   (ioctl_wait),
		.dio_write    (dio_write),
		.dl_word_addr (dl_word_addr)
	);

	// ------------------------------------------------------------
	// memory and cpu bus
	// ------------------------------------------------------------
	memory_port_mux u_mux (
		.download      (download),
		.dio_bus       (dio_bus),
		.dio_write     (dio_write),
		.disk_read_ack (disk_read_ack),
		.dl_word_addr  (dl_word_addr),
		.chip_mem      (chip_mem),
		.sdram_rdata   (sdram_rdata),
		.sdram_req     (sdram_req),
		.cpu_rdata     (cpu_rdata)
	);

	cpu_bus_ack u_ack (
		.clk32      (clk32),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.turbo      (turbo),
		.not_memory (not_memory),
		.cpu        (cpu),
		.dtack_n    (dtack_n),
		.vpa_n      (vpa_n)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_lfsr.svh ====
// Testbench random source
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// ------------------------------------------------------------
// 32-bit Fibonacci LFSR, taps 32 22 2 1
// ------------------------------------------------------------

// shared state, stepped once per random bit
logic [31:0] lfsr_state = 32'd79405;

// one shift, feedback enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

// n fresh bits, right aligned
function automatic logic [31:0] draw_bits(input int n);
	logic [31:0] value;
	value = 32'd0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
	return value;
endfunction

`endif

// ==== testbench/tb_mac_glue.sv ====
// Mac Plus glue testbench
`timescale 1ns/10ps
`default_nettype none

module tb_mac_glue
	import mac_glue_pkg::*;
();

	// three reset holds dominate the run, plus margin for the short tests
	localparam longint TEST_CLOCKS = 3 * 65536 * 4 + 20000;
	localparam longint WATCHDOG_NS = 2 * TEST_CLOCKS * 100;

	logic         clk32;
	logic         reset;
	download_t    download;
	chip_mem_t    chip_mem;
	cpu_bus_t     cpu;
	logic         turbo, mem_config, user_reset, not_memory, disk_read_ack;
	logic [1:0]   disk_eject;
	logic [15:0]  sdram_rdata;
	sdram_req_t   sdram_req;
	logic [15:0]  cpu_rdata;
	logic         dtack_n, vpa_n, n_reset, ioctl_wait;
	disk_status_t disk_status;
	logic         clk8_en_p, clk8_en_n, clk16_en_p, clk16_en_n;
	logic         video_bus, cpu_bus, dio_bus;
	logic [3:0]   cycle_phase;
	int           checks = 0;
	int           errors = 0;
	int           mark;

	`include "tb_lfsr.svh"

	mac_glue_top dut (.*);

	initial begin
		clk32 = 1'b0;
		forever #50 clk32 = ~clk32;
	end

	// clocks since reset, modulo one bus cycle
	always @(posedge clk32) begin
		if (reset) begin
			cycle_phase <= 4'd0;
		end else begin
			cycle_phase <= cycle_phase + 4'd1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Checks failed");
		$finish;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("error %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished, %0d errors", name, errors - mark);
		mark = errors;
	endtask

	// n_reset must stay low for exactly RESET_HOLD ticks from here
	task automatic count_hold();
		int n;
		n = 0;
		while (n < int'(RESET_HOLD)) begin
			check(!n_reset, "n_reset released before the hold ran out");
			if (clk8_en_p) n++;
			@(negedge clk32);
		end
		check(n_reset, "n_reset still low after the full hold");
	endtask

	// step past the next clk8 tick
	task automatic pass_tick();
		while (!clk8_en_p) @(negedge clk32);
		@(negedge clk32);
	endtask

	// enables and slot owners against the bus cycle table
	task automatic check_phase(input int n);
		logic [3:0] en_exp;
		logic [2:0] own_exp;
		repeat (n) begin
			case (cycle_phase[1:0])
				2'd0: en_exp = 4'b1010;
				2'd2: en_exp = 4'b0110;
				default: en_exp = 4'b0001;
			endcase
			// video, cpu, io, cpu
			case (cycle_phase[3:2])
				2'd0: own_exp = 3'b100;
				2'd2: own_exp = 3'b001;
				default: own_exp = 3'b010;
			endcase
			check({clk8_en_p, clk8_en_n, clk16_en_p, clk16_en_n} == en_exp,
				$sformatf("clock enables wrong at phase %0d", cycle_phase));
			check({video_bus, cpu_bus, dio_bus} == own_exp,
				$sformatf("slot ownership wrong at phase %0d", cycle_phase));
			@(negedge clk32);
		end
	endtask

	task automatic finish_image(input logic [4:0] idx, input logic [22:0] words);
		download.active = 1'b1;
		download.index  = idx;
		download.addr   = {words, 1'b0};
		@(negedge clk32);
		download.active = 1'b0;
		@(negedge clk32);
		@(negedge clk32);
	endtask

	task automatic check_disk(input logic [3:0] expected, input string what);
		check(disk_status == expected, $sformatf("disk status %b after %s, expected %b",
			disk_status, what, expected));
	endtask

	task automatic loader_write(input logic [4:0] idx, input logic [23:0] addr,
		input logic [7:0] data);
		logic [20:0] base;
		logic [24:0] exp_addr;
		logic [1:0]  exp_ds;
		int          stall;
		int          writes;
		base = (idx == IDX_ROM) ? 21'd0 : (idx == IDX_DISK_INT) ? DISK_INT_BASE : DISK_EXT_BASE;
		exp_addr = {DL_REGION_TAG, base + addr[21:1]};
		// even byte on the upper lane
		exp_ds = addr[0] ? 2'b01 : 2'b10;
		download.active = 1'b1;
		download.index  = idx;
		download.addr   = addr;
		download.data   = data;
		download.wr     = 1'b1;
		@(negedge clk32);
		download.wr = 1'b0;
		check(ioctl_wait, "ioctl_wait not raised after wr");
		stall = 0;
		writes = 0;
		while (ioctl_wait && stall <= 20) begin
			if (sdram_req.we) begin
				writes++;
				check(dio_bus, "download write outside the io slot");
				check(sdram_req.addr == exp_addr, $sformatf("write addr %h, expected %h",
					sdram_req.addr, exp_addr));
				check(sdram_req.din == {data, data}, "write data not the duplicated byte");
				check(sdram_req.ds == exp_ds, "write lane does not match byte address");
			end
			if (dio_bus) check(cpu_rdata == 16'hffff, "cpu_rdata not all ones in download cycle");
			stall++;
			@(negedge clk32);
		end
		check(stall <= 20, "loader stalled for more than 20 clocks");
		check(writes == 1, $sformatf("%0d SDRAM writes for one loader wr", writes));
		check(!sdram_req.we, "write strobe seen after the stall ended");
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [15:0] exp_rdata;
		logic [24:0] exp_req_addr;
		logic [1:0]  exp_lanes;
		logic [4:0]  dl_idx;
		logic [23:0] dl_addr;
		reset = 1'b1;
		download = '0;
		chip_mem = '0;
		chip_mem.rom_oe_n = 1'b1;
		chip_mem.ram_oe_n = 1'b1;
		chip_mem.ram_we_n = 1'b1;
		cpu = '0;
		cpu.as_n = 1'b1;
		{turbo, mem_config, user_reset, not_memory, disk_read_ack} = 5'b0;
		disk_eject = 2'b00;
		sdram_rdata = 16'h0000;
		mark = 0;
		repeat (4) @(posedge clk32);
		@(negedge clk32);
		reset = 1'b0;

		// reset hold after power up, after a config change, during a rom load
		count_hold();
		mem_config = 1'b1;
		pass_tick();
		count_hold();
		download.active = 1'b1;
		download.index  = IDX_ROM;
		pass_tick();
		repeat (64) begin
			check(!n_reset, "n_reset high during a rom download");
			@(negedge clk32);
		end
		download.active = 1'b0;
		@(negedge clk32);
		report_test("reset_hold");

		// floppy sizes, {inserted, double_sided}
		finish_image(IDX_DISK_INT, FLOPPY_DS_WORDS);
		check_disk(4'b0101, "double sided image on drive 0");
		finish_image(IDX_DISK_INT, FLOPPY_SS_WORDS);
		check_disk(4'b0100, "single sided image on drive 0");
		finish_image(IDX_DISK_INT, 23'd12345);
		check_disk(4'b0000, "unknown size on drive 0");
		finish_image(IDX_DISK_INT, FLOPPY_DS_WORDS);
		disk_eject = 2'b01;
		@(negedge clk32);
		disk_eject = 2'b00;
		@(negedge clk32);
		check_disk(4'b0000, "eject of drive 0");
		finish_image(IDX_DISK_EXT, FLOPPY_DS_WORDS);
		check_disk(4'b1010, "double sided image on drive 1");
		report_test("floppy_detect");

		// loader writes at random phases of the bus cycle
		repeat (24) begin
			r = draw_bits(2);
			repeat (int'(r[1:0])) @(negedge clk32);
			r = draw_bits(2);
			dl_idx = r[4:0];
			r = draw_bits(24);
			dl_addr = r[23:0];
			r = draw_bits(8);
			loader_write(dl_idx, dl_addr, r[7:0]);
		end
		download.active = 1'b0;
		@(negedge clk32);
		report_test("download_writes");

		// chipset requests and read data
		repeat (40) begin
			r = draw_bits(22);
			chip_mem.addr = r[21:0];
			r = draw_bits(5);
			{chip_mem.rom_oe_n, chip_mem.ram_oe_n, chip_mem.ram_we_n} = r[4:2];
			{chip_mem.uds_n, chip_mem.lds_n} = r[1:0];
			r = draw_bits(16);
			chip_mem.wdata = r[15:0];
			r = draw_bits(16);
			sdram_rdata = r[15:0];
			r = draw_bits(1);
			disk_read_ack = r[0];
			#10;
			// word address below the rom select bit
			exp_req_addr = 25'(chip_mem.addr >> 1);
			exp_req_addr[21] = (chip_mem.rom_oe_n == 1'b0);
			exp_lanes[1] = (chip_mem.uds_n == 1'b0);
			exp_lanes[0] = (chip_mem.lds_n == 1'b0);
			check(sdram_req.addr == exp_req_addr, $sformatf("chipset addr %h, expected %h",
				sdram_req.addr, exp_req_addr));
			check(sdram_req.din == chip_mem.wdata, "chipset write data");
			check(sdram_req.ds == exp_lanes, "chipset data strobes");
			check(sdram_req.we == (chip_mem.ram_we_n == 1'b0), "chipset write enable");
			check(sdram_req.oe == (chip_mem.ram_oe_n == 1'b0 || chip_mem.rom_oe_n == 1'b0),
				"chipset oe");
			if (!disk_read_ack) exp_rdata = sdram_rdata;
			else if (chip_mem.addr[0]) exp_rdata = {sdram_rdata[7:0], sdram_rdata[7:0]};
			else exp_rdata = {sdram_rdata[15:8], sdram_rdata[15:8]};
			check(cpu_rdata == exp_rdata, $sformatf("cpu_rdata %h, expected %h",
				cpu_rdata, exp_rdata));
			@(negedge clk32);
		end
		download.active = 1'b1;
		while (!dio_bus) @(negedge clk32);
		#10;
		check(cpu_rdata == 16'hffff, "cpu_rdata not all ones in download cycle");
		download.active = 1'b0;
		disk_read_ack = 1'b0;
		chip_mem.ram_we_n = 1'b1;
		@(negedge clk32);
		report_test("chipset_path");

		// bus acknowledge, memory, autovector and interrupt acknowledge
		cpu.as_n = 1'b0;
		cpu.fc = 3'b101;
		r = draw_bits(22);
		cpu.addr = {1'b0, r[21:0]};
		#10;
		check(!dtack_n && vpa_n, "memory access not acknowledged by dtack");
		cpu.addr[23:21] = IO_SPACE_TOP;
		#10;
		check(dtack_n && !vpa_n, "autovector access not answered by vpa");
		cpu.addr[23:21] = 3'b001;
		cpu.fc = FC_INTACK;
		#10;
		check(dtack_n && !vpa_n, "interrupt acknowledge not answered by vpa");
		cpu.fc = 3'b101;
		cpu.as_n = 1'b1;
		turbo = 1'b1;
		@(negedge clk32);
		while (cpu_bus) @(negedge clk32);
		cpu.as_n = 1'b0;
		#10;
		while (!cpu_bus) begin
			check(dtack_n, "turbo dtack before the cpu slot");
			@(negedge clk32);
		end
		check(dtack_n, "turbo dtack on the cpu slot edge");
		@(negedge clk32);
		check(!dtack_n, "turbo dtack missing one clock after the cpu slot");
		cpu.as_n = 1'b1;
		@(negedge clk32);
		cpu.as_n = 1'b0;
		not_memory = 1'b1;
		#10;
		check(dtack_n, "turbo peripheral dtack before its clock");
		@(negedge clk32);
		check(!dtack_n, "turbo peripheral dtack missing after one clock");
		cpu.as_n = 1'b1;
		not_memory = 1'b0;
		turbo = 1'b0;
		@(negedge clk32);
		report_test("bus_ack");

		// two full bus cycles of enables and slot owners
		check_phase(32);
		report_test("bus_phase");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+testbench
hw/mac_glue_pkg.sv
hw/bus_phase_gen.sv
hw/reset_sequencer.sv
hw/floppy_image_detect.sv
hw/download_port.sv
hw/memory_port_mux.sv
hw/cpu_bus_ack.sv
hw/mac_glue_top.sv
testbench/tb_mac_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the Mac Plus glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_mac_glue -o sim_mac_glue \
	|| { echo "build failed"; exit 1; }

./obj_dir/sim_mac_glue > sim.log 2>&1
cat sim.log

grep -q "All checks passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
